// ==== flist.f ====
hw/uart_pkg.sv
hw/word_pkg.sv
hw/baud_tick_gen.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/rx_word_assembler.sv
hw/tx_word_splitter.sv
hw/uart_word_link.sv
test/tb_clock_gen.sv
test/tb_uart_word_link.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_uart_word_link -f flist.f \
    --Mdir obj_dir -o sim_uart_word_link
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_uart_word_link
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi
exit 0

// ==== test/tb_uart_word_link.sv ====
module tb_uart_word_link;

    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;
    import word_pkg::*;

    // Fast baud for simulation
    localparam int clks_per_tick = 4;
    // Serial bit and frame length in clk cycles
    localparam int bit_cycles   = os_rate * clks_per_tick;
    localparam int frame_cycles = bit_cycles * (data_bits + 2);
    localparam logic [31:0] seed = 32'h83eb_0523;

    logic  clk;
    logic  arst_n;
    logic  rx;
    logic  tx;
    logic  frame_err;
    logic  write;
    addr_t wr_addr;
    word_t wr_data;
    logic  word_start;
    word_t tx_word;
    logic  tx_ready;

    // Reference model, expected writes and expected line bytes
    word_t       exp_wr[$];
    byte_t       exp_tx[$];
    addr_t       exp_addr;
    int          exp_writes;
    int          writes_seen;
    int          frame_errs_seen;
    word_t       want_data;
    logic [31:0] lfsr_state;

    tb_clock_gen #(
        .period      (40),
        .reset_cycles(16)
    ) u_clk (
        .clk   (clk),
        .arst_n(arst_n)
    );

    uart_word_link #(
        .clks_per_tick(clks_per_tick)
    ) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .tx        (tx),
        .frame_err (frame_err),
        .write     (write),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .word_start(word_start),
        .tx_word   (tx_word),
        .tx_ready  (tx_ready)
    );

    ////////////////////////////////////////////////////////////
    // Failure handling and the single compare
    ////////////////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("sim failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Fail %s got 0x%08h expected 0x%08h", name, got, want);
            stop_on_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Random source, taps 32 22 2 1
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Monitors on the parallel side
    ////////////////////////////////////////////////////////////

    // Each write pops one model word, address counted from zero
    always @(negedge clk) begin
        if (arst_n && write) begin
            if (exp_wr.size() == 0) begin
                $display("A write appeared with no word expected");
                stop_on_failure();
            end else begin
                want_data = exp_wr.pop_front();
                check_value("wr_data", wr_data, want_data);
                check_value("wr_addr", wr_addr, exp_addr);
                exp_addr = exp_addr + addr_step;
                writes_seen++;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n && frame_err) begin
            frame_errs_seen++;
        end
    end

    ////////////////////////////////////////////////////////////
    // Waits, each with its own cycle limit
    ////////////////////////////////////////////////////////////

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1) begin
            if (cycles == 100) begin
                $display("Timeout waiting for reset release");
                stop_on_failure();
            end
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
    endtask

    task automatic wait_writes(input int n);
        int cycles;
        cycles = 0;
        while (writes_seen < n) begin
            if (cycles == 2 * frame_cycles) begin
                $display("Timeout waiting for a write from the receive path");
                stop_on_failure();
            end
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
    endtask

    task automatic wait_frame_errs(input int n);
        int cycles;
        cycles = 0;
        while (frame_errs_seen < n) begin
            if (cycles == 2 * frame_cycles) begin
                $display("Timeout waiting for frame_err after a bad stop bit");
                stop_on_failure();
            end
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
    endtask

    task automatic wait_tx_ready();
        int cycles;
        cycles = 0;
        while (tx_ready !== 1'b1) begin
            if (cycles == 2 * frame_cycles) begin
                $display("Timeout waiting for tx_ready to rise");
                stop_on_failure();
            end
            @(posedge clk);
            cycles++;
        end
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Serial line driver and monitor
    ////////////////////////////////////////////////////////////

    // 8N1 frame on rx, LSB first, called on a falling edge
    task automatic send_serial_byte(input byte_t b, input logic good_stop);
        int k;
        rx = 1'b0;
        repeat (bit_cycles) @(negedge clk);
        for (k = 0; k < data_bits; k++) begin
            rx = b[k];
            repeat (bit_cycles) @(negedge clk);
        end
        if (good_stop) begin
            rx = 1'b1;
            repeat (bit_cycles) @(negedge clk);
        end else begin
            // Low past the stop sample only, then idle so the false start dies as a glitch
            rx = 1'b0;
            repeat (bit_cycles * 3 / 4) @(negedge clk);
            rx = 1'b1;
            repeat (bit_cycles * 2) @(negedge clk);
        end
    endtask

    task automatic send_rx_word(input word_t w);
        int k;
        exp_wr.push_back(w);
        exp_writes++;
        for (k = 0; k < bytes_per_word; k++) begin
            send_serial_byte(w[8*k +: 8], 1'b1);
        end
    endtask

    // Samples tx at the bit midpoints
    task automatic receive_tx_byte(output byte_t b);
        int cycles;
        int k;
        cycles = 0;
        b = '0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            if (cycles == 4 * frame_cycles) begin
                $display("Timeout waiting for a start bit on tx");
                stop_on_failure();
            end
            @(negedge clk);
            cycles++;
        end
        repeat (bit_cycles / 2) @(negedge clk);
        check_value("tx start bit", 32'(tx), 32'h0);
        for (k = 0; k < data_bits; k++) begin
            repeat (bit_cycles) @(negedge clk);
            b[k] = tx;
        end
        repeat (bit_cycles) @(negedge clk);
        check_value("tx stop bit", 32'(tx), 32'h1);
        // Word still in flight at every stop bit
        check_value("tx_ready", 32'(tx_ready), 32'h0);
    endtask

    task automatic collect_tx_word();
        byte_t b;
        byte_t want;
        int    k;
        for (k = 0; k < bytes_per_word; k++) begin
            receive_tx_byte(b);
            if (exp_tx.size() == 0) begin
                $display("A byte appeared on tx with none expected");
                stop_on_failure();
            end
            want = exp_tx.pop_front();
            check_value("tx byte", 32'(b), 32'(want));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Transmit handshake
    ////////////////////////////////////////////////////////////

    task automatic start_tx_word(input word_t w);
        int k;
        check_value("tx_ready", 32'(tx_ready), 32'h1);
        for (k = 0; k < bytes_per_word; k++) begin
            exp_tx.push_back(w[8*k +: 8]);
        end
        word_start = 1'b1;
        tx_word    = w;
        @(negedge clk);
        word_start = 1'b0;
        check_value("tx_ready", 32'(tx_ready), 32'h0);
    endtask

    // Start pulse while busy, must leave no trace on tx
    task automatic pulse_while_busy(input word_t w);
        check_value("tx_ready", 32'(tx_ready), 32'h0);
        word_start = 1'b1;
        tx_word    = w;
        @(negedge clk);
        word_start = 1'b0;
    endtask

    task automatic hold_tx_idle(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(negedge clk);
            check_value("tx", 32'(tx), 32'h1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        word_t w;
        word_t w2;
        int    k;
        lfsr_state      = seed;
        rx              = 1'b1;
        word_start      = 1'b0;
        tx_word         = '0;
        exp_addr        = '0;
        exp_writes      = 0;
        writes_seen     = 0;
        frame_errs_seen = 0;
        wait_reset_release();

        // Idle levels out of reset
        check_value("tx", 32'(tx), 32'h1);
        check_value("tx_ready", 32'(tx_ready), 32'h1);
        check_value("write", 32'(write), 32'h0);
        check_value("frame_err", 32'(frame_err), 32'h0);
        check_value("wr_addr", wr_addr, 32'h0);

        // Random words in, one write each
        for (k = 0; k < 5; k++) begin
            draw_bits(32, w);
            send_rx_word(w);
        end
        wait_writes(exp_writes);

        // One word out
        draw_bits(32, w);
        start_tx_word(w);
        collect_tx_word();
        wait_tx_ready();
        check_value("tx", 32'(tx), 32'h1);

        // Extra starts during a send are dropped
        draw_bits(32, w);
        fork
            begin
                start_tx_word(w);
                repeat (100) @(negedge clk);
                draw_bits(32, w2);
                pulse_while_busy(w2);
                repeat (600) @(negedge clk);
                pulse_while_busy(~w2);
                repeat (900) @(negedge clk);
                pulse_while_busy(w2 ^ w);
            end
            collect_tx_word();
        join
        wait_tx_ready();
        hold_tx_idle(2 * bit_cycles);

        // Bad stop bit, byte dropped, lane count untouched
        draw_bits(8, w);
        send_serial_byte(w[7:0], 1'b0);
        wait_frame_errs(1);
        draw_bits(32, w);
        send_rx_word(w);
        wait_writes(exp_writes);

        // Both directions at once
        draw_bits(32, w);
        fork
            begin
                start_tx_word(w);
                collect_tx_word();
            end
            begin
                draw_bits(32, w2);
                send_rx_word(w2);
                draw_bits(32, w2);
                send_rx_word(w2);
            end
        join
        wait_writes(exp_writes);
        wait_tx_ready();

        // Quiet line, nothing left in the model
        hold_tx_idle(bit_cycles);
        if ((writes_seen == exp_writes) && (frame_errs_seen == 1) &&
            (exp_tx.size() == 0) && (exp_wr.size() == 0)) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Write, frame error or tx byte counts differ from the model at the end");
            stop_on_failure();
        end
    end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // Free-running clock, starts low
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset held over the first cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// ==== hw/uart_word_link.sv ====
module uart_word_link #(
    parameter int clks_per_tick = 27
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rx,
    output logic            tx,
    output logic            frame_err,
    output logic            write,
    output word_pkg::addr_t wr_addr,
    output word_pkg::word_t wr_data,
    input  logic            word_start,
    input  word_pkg::word_t tx_word,
    output logic            tx_ready
);

    import uart_pkg::*;

    // Shared oversampling strobe
    logic  tick;
    // Receive byte path
    byte_t rx_byte;
    logic  rx_done;
    // Transmit byte handshake
    logic  tx_start;
    byte_t tx_byte;
    logic  tx_done;

    ////////////////////////////////////////////////////////////
    // Baud timing
    ////////////////////////////////////////////////////////////

    baud_tick_gen #(
        .clks_per_tick(clks_per_tick)
    ) u_baud (
        .clk   (clk),
        .arst_n(arst_n),
        .tick  (tick)
    );

    ////////////////////////////////////////////////////////////
    // Receive path, serial to addressed writes
    ////////////////////////////////////////////////////////////

    uart_rx u_rx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_done  (rx_done),
        .frame_err(frame_err)
    );

    rx_word_assembler u_rx_asm (
        .clk    (clk),
        .arst_n (arst_n),
        .rx_done(rx_done),
        .rx_byte(rx_byte),
        .write  (write),
        .wr_addr(wr_addr),
        .wr_data(wr_data)
    );

    ////////////////////////////////////////////////////////////
    // Transmit path, result word to serial
    ////////////////////////////////////////////////////////////

    tx_word_splitter u_tx_split (
        .clk       (clk),
        .arst_n    (arst_n),
        .word_start(word_start),
        .tx_word   (tx_word),
        .tx_ready  (tx_ready),
        .tx_start  (tx_start),
        .tx_byte   (tx_byte),
        .tx_done   (tx_done)
    );

    uart_tx u_tx (
        .clk     (clk),
        .arst_n  (arst_n),
        .tick    (tick),
        .tx_start(tx_start),
        .tx_byte (tx_byte),
        .tx      (tx),
        .tx_done (tx_done)
    );

endmodule

// ==== hw/tx_word_splitter.sv ====
module tx_word_splitter (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            word_start,
    input  word_pkg::word_t tx_word,
    output logic            tx_ready,
    output logic            tx_start,
    output uart_pkg::byte_t tx_byte,
    input  logic            tx_done
);

    import uart_pkg::*;
    import word_pkg::*;

    // Width of one byte lane
    localparam int lane_bits = $bits(byte_t);

    logic [lane_w-1:0] lane;
    word_t             word_q;
    logic              accept;
    logic              last_lane;

    // Starts outside the idle state are dropped
    assign accept = word_start && tx_ready;
    assign last_lane = (lane == lane_w'(bytes_per_word - 1));

    ////////////////////////////////////////////////////////////
    // Byte sequencer, tx_ready is the idle state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_ready <= 1'b1;
            tx_start <= 1'b0;
            lane     <= '0;
        end else begin
            tx_start <= 1'b0;
            if (accept) begin
                // Lane 0 goes out right away
                tx_ready <= 1'b0;
                tx_start <= 1'b1;
                lane     <= '0;
            end else if (!tx_ready && tx_done) begin
                if (last_lane) begin
                    tx_ready <= 1'b1;
                end else begin
                    lane     <= lane + 1'b1;
                    tx_start <= 1'b1;
                end
            end
        end
    end

    // Word copy for the whole send
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= tx_word;
        end
    end

    // Lane select, LSB first
    assign tx_byte = word_q[lane*lane_bits +: lane_bits];

    a_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> !tx_ready)
        else $error("tx_start outside a word");

endmodule

// ==== hw/rx_word_assembler.sv ====
module rx_word_assembler (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            rx_done,
    input  uart_pkg::byte_t rx_byte,
    output logic            write,
    output word_pkg::addr_t wr_addr,
    output word_pkg::word_t wr_data
);

    import uart_pkg::*;
    import word_pkg::*;

    // Width of one byte lane
    localparam int lane_bits = $bits(byte_t);

    logic [lane_w-1:0] byte_cnt;
    logic              last_lane;

    // Fourth byte of the word
    assign last_lane = (byte_cnt == lane_w'(bytes_per_word - 1));

    ////////////////////////////////////////////////////////////
    // Lane counter, write strobe, address
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            byte_cnt <= '0;
            write    <= 1'b0;
            wr_addr  <= '0;
        end else begin
            // One cycle after the closing byte
            write <= rx_done && last_lane;
            if (rx_done) begin
                byte_cnt <= last_lane ? '0 : byte_cnt + 1'b1;
            end
            // Address moves on once the write is out
            if (write) begin
                wr_addr <= wr_addr + addr_step;
            end
        end
    end

    // Byte lanes filled from lane 0 upward
    always_ff @(posedge clk) begin
        if (rx_done) begin
            wr_data[byte_cnt*lane_bits +: lane_bits] <= rx_byte;
        end
    end

    a_write_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        write |=> !write)
        else $error("write held longer than one cycle");

endmodule

// ==== hw/uart_tx.sv ====
module uart_tx (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            tick,
    input  logic            tx_start,
    input  uart_pkg::byte_t tx_byte,
    output logic            tx,
    output logic            tx_done
);

    import uart_pkg::*;

    // FSM encoding
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic [1:0]        state;
    logic [tick_w-1:0] tick_cnt;
    logic [bit_w-1:0]  bit_cnt;
    byte_t             shreg;
    logic              bit_end;

    // Current bit has lasted os_rate ticks
    assign bit_end = tick && (tick_cnt == tick_w'(os_rate - 1));

    ////////////////////////////////////////////////////////////
    // Frame FSM, line driven from a register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
            tx_done  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (tx_start) begin
                        // Start bit on the next cycle
                        state    <= st_start;
                        tick_cnt <= '0;
                        tx       <= 1'b0;
                    end
                end
                st_start: begin
                    if (bit_end) begin
                        state    <= st_data;
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        tx       <= shreg[0];
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_cnt == bit_w'(data_bits - 1)) begin
                            state <= st_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            // Next bit before the shift lands
                            tx      <= shreg[1];
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        state   <= st_idle;
                        tx_done <= 1'b1;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Byte latch and LSB-first shift
    always_ff @(posedge clk) begin
        if ((state == st_idle) && tx_start) begin
            shreg <= tx_byte;
        end else if ((state == st_data) && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> (state == st_idle))
        else $error("tx_start while transmitter busy");

endmodule

// ==== hw/uart_rx.sv ====
module uart_rx (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            tick,
    input  logic            rx,
    output uart_pkg::byte_t rx_byte,
    output logic            rx_done,
    output logic            frame_err
);

    import uart_pkg::*;

    // FSM encoding
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic              rx_meta;
    logic              rx_sync;
    logic [1:0]        state;
    logic [tick_w-1:0] tick_cnt;
    logic [bit_w-1:0]  bit_cnt;
    byte_t             shreg;
    logic              start_mid;
    logic              bit_end;

    // Middle of the start bit
    assign start_mid = tick && (tick_cnt == tick_w'(mid_tick - 1));
    // One full bit after the last sample point
    assign bit_end = tick && (tick_cnt == tick_w'(os_rate - 1));

    ////////////////////////////////////////////////////////////
    // Input synchronizer
    ////////////////////////////////////////////////////////////

    // Idle line is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            tick_cnt  <= '0;
            bit_cnt   <= '0;
            rx_done   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            // Status flags are single-cycle pulses
            rx_done   <= 1'b0;
            frame_err <= 1'b0;
            case (state)
                st_idle: begin
                    // Falling edge starts the midpoint search
                    if (!rx_sync) begin
                        state    <= st_start;
                        tick_cnt <= '0;
                    end
                end
                st_start: begin
                    if (start_mid) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        // High at midpoint means a glitch
                        state    <= rx_sync ? st_idle : st_data;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == bit_w'(data_bits - 1)) begin
                            state <= st_stop;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        state     <= st_idle;
                        // Low stop bit drops the byte
                        rx_done   <= rx_sync;
                        frame_err <= !rx_sync;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Data shift, LSB arrives first
    always_ff @(posedge clk) begin
        if ((state == st_data) && bit_end) begin
            shreg <= {rx_sync, shreg[data_bits-1:1]};
        end
    end

    assign rx_byte = shreg;

    a_done_xor_err: assert property (@(posedge clk) disable iff (!arst_n)
        !(rx_done && frame_err))
        else $error("rx_done and frame_err high together");

endmodule

// ==== hw/baud_tick_gen.sv ====
module baud_tick_gen #(
    parameter int clks_per_tick = 27
) (
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    // Keep at least one bit when no division is asked for
    localparam int cnt_w = (clks_per_tick > 1) ? $clog2(clks_per_tick) : 1;

    logic [cnt_w-1:0] cnt;
    logic             wrap;

    // Last count before wrapping
    assign wrap = (cnt == cnt_w'(clks_per_tick - 1));

    // Free-running divider, tick is registered on the wrap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            cnt  <= wrap ? '0 : cnt + 1'b1;
            tick <= wrap;
        end
    end

    // Ticks stay isolated pulses once the divider is real
    a_tick_single: assert property (@(posedge clk) disable iff (!arst_n)
        ((clks_per_tick > 1) && tick) |=> !tick)
        else $error("tick high on two consecutive cycles");

endmodule

// ==== hw/word_pkg.sv ====
package word_pkg;

    ////////////////////////////////////////////////////////////
    // Parallel side of the link
    ////////////////////////////////////////////////////////////

    // Width of one memory word
    localparam int word_bits = 32;

    // Serial bytes packed into one word
    localparam int bytes_per_word = 4;

    // Byte lane index width
    localparam int lane_w = $clog2(bytes_per_word);

    // Data word and write address
    typedef logic [word_bits-1:0] word_t;
    typedef logic [31:0] addr_t;

    // Byte addressing, one word per write
    localparam addr_t addr_step = 32'd4;

endpackage

// ==== hw/uart_pkg.sv ====
package uart_pkg;

    ////////////////////////////////////////////////////////////
    // Serial frame timing, 8N1
    ////////////////////////////////////////////////////////////

    // Oversampling ticks per serial bit
    localparam int os_rate = 16;

    // Data bits carried in one frame
    localparam int data_bits = 8;

    // Tick count to the middle of a bit cell
    localparam int mid_tick = os_rate / 2;

    // Counter widths for tick and bit positions
    localparam int tick_w = $clog2(os_rate);
    localparam int bit_w = $clog2(data_bits);

    ////////////////////////////////////////////////////////////
    // Serial payload
    ////////////////////////////////////////////////////////////

    // One received or transmitted byte
    typedef logic [data_bits-1:0] byte_t;

endpackage
